// ==== Bender.yml ====
package:
  name: sdram_boot

sources:
  - design/sdram_boot_pkg.sv
  - design/rom_download_writer.sv
  - design/ram_zero_sweeper.sv
  - design/sdram_boot_arbiter.sv
  - design/sdram_boot_top.sv
  - target: simulation
    files:
      - verif/sdram_boot_props.sv
      - verif/sdram_boot_tb.sv

// ==== all.f ====
design/sdram_boot_pkg.sv
design/rom_download_writer.sv
design/ram_zero_sweeper.sv
design/sdram_boot_arbiter.sv
design/sdram_boot_top.sv
verif/sdram_boot_props.sv
verif/sdram_boot_tb.sv

// ==== design/ram_zero_sweeper.sv ====
`timescale 1ns/100ps

module ram_zero_sweeper #(
    parameter int ZERO_WORDS = sdram_boot_pkg::ZERO_WORDS_DEFAULT
) (
    input  logic                        clk_sys,
    input  logic                        rst,

    // Start of a new download restarts the sweep
    input  logic                        dl_active,

    // Word write request towards the arbiter
    output logic                        zero_req,
    output sdram_boot_pkg::sdram_addr_t zero_addr,
    input  logic                        zero_done_pulse,

    output logic                        sweep_done
);

    // Counter needs to hold ZERO_WORDS itself as the end marker
    localparam int CNT_W = $clog2(ZERO_WORDS + 1);

    logic [CNT_W-1:0] word_cnt;

    // Previous dl_active for edge detection
    logic dl_active_q;
    logic restart;

    // ============================================================
    // Restart detection
    // ============================================================

    assign restart = dl_active && !dl_active_q;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            dl_active_q <= 1'b0;
        end else begin
            dl_active_q <= dl_active;
        end
    end

    // ============================================================
    // Word counter
    // ============================================================

    // Advances once per finished write
    always_ff @(posedge clk_sys) begin
        if (rst || restart) begin
            word_cnt <= '0;
        end else if (zero_done_pulse && zero_req) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // Done as soon as the count reaches the region size,
    // one cycle after the last completion
    assign sweep_done = (word_cnt >= CNT_W'(ZERO_WORDS));
    assign zero_req   = !sweep_done;

    // Byte address of the current word
    assign zero_addr = sdram_boot_pkg::sdram_addr_t'({word_cnt, 1'b0});

endmodule

// ==== design/rom_download_writer.sv ====
`timescale 1ns/100ps

module rom_download_writer (
    input  logic                       clk_sys,
    input  logic                       rst,

    // Host download stream
    input  logic                       dl_valid,
    output logic                       dl_ready,
    input  sdram_boot_pkg::dl_addr_t   dl_addr,
    input  sdram_boot_pkg::sdram_data_t dl_data,

    // Write request towards the arbiter
    output logic                       rom_req,
    output sdram_boot_pkg::sdram_addr_t rom_addr,
    output sdram_boot_pkg::sdram_data_t rom_data,
    input  logic                       rom_done
);

    // Word accepted this cycle
    logic accept;

    // Word index inside the ROM region, taken from the byte address
    logic [sdram_boot_pkg::ROM_ADDR_BITS-1:0] word_idx;

    // Offset from ROM base, word index with the byte bit cleared
    sdram_boot_pkg::sdram_addr_t rom_offset;

    // Swapped copy of the incoming word
    sdram_boot_pkg::sdram_data_t data_swapped;

    // ============================================================
    // Handshake
    // ============================================================

    // Only one write may be outstanding
    // Ready drops with the accepting edge and returns after rom_done
    assign dl_ready = !rom_req;
    assign accept   = dl_valid && dl_ready;

    // ============================================================
    // Address and data formatting
    // ============================================================

    // Bits 21..1 of the download address
    assign word_idx = dl_addr[sdram_boot_pkg::ROM_ADDR_BITS:1];

    assign rom_offset = sdram_boot_pkg::sdram_addr_t'({word_idx, 1'b0});

    // Host sends little endian words, SDRAM expects them swapped
    assign data_swapped = {dl_data[7:0], dl_data[15:8]};

    // ============================================================
    // Pending write
    // ============================================================

    // Request flag, set on accept and held until the arbiter
    // reports the write complete
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            rom_req <= 1'b0;
        end else if (accept) begin
            rom_req <= 1'b1;
        end else if (rom_done) begin
            rom_req <= 1'b0;
        end
    end

    // Payload only, loaded together with the request flag
    always_ff @(posedge clk_sys) begin
        if (accept) begin
            rom_addr <= sdram_boot_pkg::ROM_BASE + rom_offset;
            rom_data <= data_swapped;
        end
    end

endmodule

// ==== design/sdram_boot_arbiter.sv ====
`timescale 1ns/100ps

module sdram_boot_arbiter (
    input  logic                        clk_sys,
    input  logic                        rst,

    // Core reset causes
    input  logic                        menu_reset,
    input  logic                        dl_active,
    input  logic                        sweep_done,
    output logic                        core_reset,

    // ROM download writer
    input  logic                        rom_req,
    input  sdram_boot_pkg::sdram_addr_t rom_addr,
    input  sdram_boot_pkg::sdram_data_t rom_data,
    output logic                        rom_done,

    // RAM zero sweeper
    input  logic                        zero_req,
    input  sdram_boot_pkg::sdram_addr_t zero_addr,
    output logic                        zero_done_pulse,

    // Core request port
    input  sdram_boot_pkg::sdram_addr_t core_addr,
    input  logic                        core_rd,
    input  logic                        core_wr,
    input  logic                        core_word,
    input  sdram_boot_pkg::sdram_data_t core_din,
    input  logic                        core_refresh,
    input  logic                        core_burst,

    // SDRAM controller port
    output sdram_boot_pkg::sdram_addr_t sdram_addr,
    output sdram_boot_pkg::sdram_data_t sdram_din,
    output logic                        sdram_rd,
    output logic                        sdram_wr,
    output logic                        sdram_word,
    output logic                        sdram_refresh,
    output logic                        sdram_burst,
    input  logic                        sdram_busy
);

    sdram_boot_pkg::sdram_owner_e owner_next;
    sdram_boot_pkg::sdram_owner_e owner;
    sdram_boot_pkg::sdram_owner_e owner_q;

    logic busy_q;
    // Held low through reset and one cycle after
    logic run_q;
    logic issue;
    logic completed;

    // Bring-up request before the output mux
    sdram_boot_pkg::sdram_addr_t bu_addr;
    sdram_boot_pkg::sdram_data_t bu_din;
    logic                        bu_rd;
    logic                        bu_wr;
    logic                        bu_refresh;

    // ============================================================
    // Core reset and state registers
    // ============================================================

    // Core stays in reset while any bring-up work is left
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            core_reset <= 1'b1;
            owner_q    <= sdram_boot_pkg::IDLE;
            busy_q     <= 1'b0;
            run_q      <= 1'b0;
        end else begin
            core_reset <= menu_reset || dl_active || !sweep_done || rom_req;
            owner_q    <= owner;
            busy_q     <= sdram_busy;
            run_q      <= 1'b1;
        end
    end

    // ============================================================
    // Owner selection
    // ============================================================

    // Later assignments win, so the highest priority goes last
    always_comb begin
        owner_next = sdram_boot_pkg::IDLE;
        if (core_reset) begin
            owner_next = sdram_boot_pkg::REFRESH;
            if (zero_req) owner_next = sdram_boot_pkg::RAM_ZERO;
            if (rom_req) owner_next = sdram_boot_pkg::ROM_DOWNLOAD;
        end
        // Keep the owner of the access in flight
        owner = sdram_busy ? owner_q : owner_next;
    end

    // Falling edge of busy ends the access
    assign completed = busy_q && !sdram_busy;

    // Skip the completion cycle so a finished owner is not served twice
    assign issue = run_q && !sdram_busy && !busy_q;

    assign rom_done        = completed && (owner_q == sdram_boot_pkg::ROM_DOWNLOAD);
    assign zero_done_pulse = completed && (owner_q == sdram_boot_pkg::RAM_ZERO);

    // ============================================================
    // Bring-up request
    // ============================================================

    always_comb begin
        bu_addr    = zero_addr;
        bu_din     = '0;
        bu_rd      = 1'b0;
        bu_wr      = 1'b0;
        bu_refresh = 1'b0;
        case (owner)
            sdram_boot_pkg::ROM_DOWNLOAD: begin
                bu_addr = rom_addr;
                bu_din  = rom_data;
                bu_wr   = issue;
            end
            sdram_boot_pkg::RAM_ZERO: begin
                bu_wr = issue;
            end
            // Refresh goes out as a read with the refresh flag
            sdram_boot_pkg::REFRESH: begin
                bu_rd      = issue;
                bu_refresh = issue;
            end
            default: begin
            end
        endcase
    end

    // ============================================================
    // SDRAM port mux
    // ============================================================

    // Word mode and no burst during bring-up
    assign sdram_addr    = core_reset ? bu_addr    : core_addr;
    assign sdram_din     = core_reset ? bu_din     : core_din;
    assign sdram_rd      = core_reset ? bu_rd      : core_rd;
    assign sdram_wr      = core_reset ? bu_wr      : core_wr;
    assign sdram_word    = core_reset ? 1'b1       : core_word;
    assign sdram_refresh = core_reset ? bu_refresh : core_refresh;
    assign sdram_burst   = core_reset ? 1'b0       : core_burst;

endmodule

// ==== design/sdram_boot_pkg.sv ====
package sdram_boot_pkg;

    // ============================================================
    // Widths
    // ============================================================

    localparam int SDRAM_ADDR_W = 25;
    localparam int SDRAM_DATA_W = 16;
    localparam int DL_ADDR_W    = 25;

    // Byte address into SDRAM, bit 0 always zero for word accesses
    typedef logic [SDRAM_ADDR_W-1:0] sdram_addr_t;

    // One 16-bit SDRAM data word
    typedef logic [SDRAM_DATA_W-1:0] sdram_data_t;

    // Byte address as delivered by the host download
    typedef logic [DL_ADDR_W-1:0] dl_addr_t;

    // ============================================================
    // Memory map
    // ============================================================

    // ROM sits above the RAM area, selected by address bit 22
    localparam sdram_addr_t ROM_BASE = sdram_addr_t'(1) << 22;

    // Download byte address bits 21..1 select the ROM word
    localparam int ROM_ADDR_BITS = 21;

    // Low RAM cleared after reset, 1 MB as 16-bit words
    localparam int ZERO_WORDS_DEFAULT = 512 * 1024;

    // ============================================================
    // Bring-up ownership of the SDRAM port
    // ============================================================

    // Listed in falling priority
    typedef enum logic [1:0] {
        ROM_DOWNLOAD,
        RAM_ZERO,
        REFRESH,
        IDLE
    } sdram_owner_e;

endpackage

// ==== design/sdram_boot_top.sv ====
`timescale 1ns/100ps

module sdram_boot_top #(
    parameter int ZERO_WORDS = sdram_boot_pkg::ZERO_WORDS_DEFAULT
) (
    input  logic                        clk_sys,
    input  logic                        rst,

    // Host side
    input  logic                        menu_reset,
    input  logic                        dl_active,
    input  logic                        dl_valid,
    output logic                        dl_ready,
    input  sdram_boot_pkg::dl_addr_t    dl_addr,
    input  sdram_boot_pkg::sdram_data_t dl_data,

    // Core side
    output logic                        core_reset,
    input  sdram_boot_pkg::sdram_addr_t core_addr,
    input  logic                        core_rd,
    input  logic                        core_wr,
    input  logic                        core_word,
    input  sdram_boot_pkg::sdram_data_t core_din,
    input  logic                        core_refresh,
    input  logic                        core_burst,

    // SDRAM controller; read data goes straight to the core
    output sdram_boot_pkg::sdram_addr_t sdram_addr,
    output sdram_boot_pkg::sdram_data_t sdram_din,
    output logic                        sdram_rd,
    output logic                        sdram_wr,
    output logic                        sdram_word,
    output logic                        sdram_refresh,
    output logic                        sdram_burst,
    input  logic                        sdram_busy
);

    // ============================================================
    // Internal request wires
    // ============================================================

    logic                        rom_req;
    sdram_boot_pkg::sdram_addr_t rom_addr;
    sdram_boot_pkg::sdram_data_t rom_data;
    logic                        rom_done;

    logic                        zero_req;
    sdram_boot_pkg::sdram_addr_t zero_addr;
    logic                        zero_done_pulse;
    logic                        sweep_done;

    // Download words into the ROM region
    rom_download_writer u_rom_writer (
        .clk_sys  (clk_sys),
        .rst      (rst),
        .dl_valid (dl_valid),
        .dl_ready (dl_ready),
        .dl_addr  (dl_addr),
        .dl_data  (dl_data),
        .rom_req  (rom_req),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_done (rom_done)
    );

    // Clear low RAM after reset and at each download start
    ram_zero_sweeper #(
        .ZERO_WORDS (ZERO_WORDS)
    ) u_zero_sweeper (
        .clk_sys         (clk_sys),
        .rst             (rst),
        .dl_active       (dl_active),
        .zero_req        (zero_req),
        .zero_addr       (zero_addr),
        .zero_done_pulse (zero_done_pulse),
        .sweep_done      (sweep_done)
    );

    sdram_boot_arbiter u_arbiter (
        .clk_sys         (clk_sys),
        .rst             (rst),
        .menu_reset      (menu_reset),
        .dl_active       (dl_active),
        .sweep_done      (sweep_done),
        .core_reset      (core_reset),
        .rom_req         (rom_req),
        .rom_addr        (rom_addr),
        .rom_data        (rom_data),
        .rom_done        (rom_done),
        .zero_req        (zero_req),
        .zero_addr       (zero_addr),
        .zero_done_pulse (zero_done_pulse),
        .core_addr       (core_addr),
        .core_rd         (core_rd),
        .core_wr         (core_wr),
        .core_word       (core_word),
        .core_din        (core_din),
        .core_refresh    (core_refresh),
        .core_burst      (core_burst),
        .sdram_addr      (sdram_addr),
        .sdram_din       (sdram_din),
        .sdram_rd        (sdram_rd),
        .sdram_wr        (sdram_wr),
        .sdram_word      (sdram_word),
        .sdram_refresh   (sdram_refresh),
        .sdram_burst     (sdram_burst),
        .sdram_busy      (sdram_busy)
    );

endmodule

// ==== verif/sdram_boot_props.sv ====
`timescale 1ns/100ps

module sdram_boot_props (
    input logic clk_sys,
    input logic rst,
    input logic core_reset,
    input logic issue,
    input logic sdram_rd,
    input logic sdram_wr,
    input logic sdram_refresh,
    input logic sdram_busy
);

    // Failed assertions, read by the testbench at the end of the run
    int unsigned failures = 0;

    // ============================================================
    // SDRAM request protocol
    // ============================================================

    // Controller takes requests only while idle
    a_no_req_while_busy: assert property (
        @(posedge clk_sys) disable iff (rst)
        sdram_busy |-> !(sdram_rd || sdram_wr)
    ) else begin
        failures++;
        $error("SDRAM request while busy");
    end

    a_rd_wr_exclusive: assert property (
        @(posedge clk_sys) disable iff (rst)
        !(sdram_rd && sdram_wr)
    ) else begin
        failures++;
        $error("rd and wr in the same cycle");
    end

    // Requests are single-cycle pulses
    a_single_pulse: assert property (
        @(posedge clk_sys) disable iff (rst)
        (sdram_rd || sdram_wr) |=> !(sdram_rd || sdram_wr)
    ) else begin
        failures++;
        $error("SDRAM request held longer than one cycle");
    end

    // ============================================================
    // Ownership
    // ============================================================

    // During bring-up only the arbiter's own issue slot reaches the SDRAM
    a_core_blocked: assert property (
        @(posedge clk_sys) disable iff (rst)
        (core_reset && !issue) |-> !(sdram_rd || sdram_wr)
    ) else begin
        failures++;
        $error("core request passed while core_reset high");
    end

    // Refresh travels as a flagged read
    a_refresh_with_rd: assert property (
        @(posedge clk_sys) disable iff (rst)
        sdram_refresh |-> sdram_rd
    ) else begin
        failures++;
        $error("refresh without rd");
    end

endmodule

// ==== verif/sdram_boot_tb.sv ====
`timescale 1ns/100ps

module sdram_boot_tb;

    // Short zero region keeps each sweep brief
    localparam int ZERO_WORDS  = 32;
    // Model holds 4k RAM words and 4k ROM words
    localparam int MEM_WORDS   = 8192;
    localparam int MAX_RECORDS = 32;

    logic                        clk_sys;
    logic                        rst;
    logic                        menu_reset;
    logic                        dl_active;
    logic                        dl_valid;
    logic                        dl_ready;
    sdram_boot_pkg::dl_addr_t    dl_addr;
    sdram_boot_pkg::sdram_data_t dl_data;
    logic                        core_reset;
    sdram_boot_pkg::sdram_addr_t core_addr;
    logic                        core_rd;
    logic                        core_wr;
    logic                        core_word;
    sdram_boot_pkg::sdram_data_t core_din;
    logic                        core_refresh;
    logic                        core_burst;
    sdram_boot_pkg::sdram_addr_t sdram_addr;
    sdram_boot_pkg::sdram_data_t sdram_din;
    logic                        sdram_rd;
    logic                        sdram_wr;
    logic                        sdram_word;
    logic                        sdram_refresh;
    logic                        sdram_burst;
    logic                        sdram_busy;
    sdram_boot_pkg::sdram_data_t sdram_dout;

    // SDRAM model state
    sdram_boot_pkg::sdram_data_t mem [0:MEM_WORDS-1];
    int unsigned                 wr_count [0:MEM_WORDS-1];
    int                          busy_left;
    logic                        rom_access;
    logic                        done_rom;
    logic                        zero_access;
    logic                        done_zero;
    integer                      seed = 32'hdf32;

    // Three entries per record: kind, address, data
    logic [31:0] testdata [0:3*MAX_RECORDS-1];
    int          n_records;
    int          n_downloads;
    int          rom_writes;
    int          zero_writes;
    int          cycle_count;
    int          cycle_limit;
    logic        monitor_armed = 1'b0;
    logic        reset_cause_q;
    logic        rom_pending;
    logic        dl_active_prev;

    bind sdram_boot_arbiter sdram_boot_props u_props (
        .clk_sys       (clk_sys),
        .rst           (rst),
        .core_reset    (core_reset),
        .issue         (issue),
        .sdram_rd      (sdram_rd),
        .sdram_wr      (sdram_wr),
        .sdram_refresh (sdram_refresh),
        .sdram_busy    (sdram_busy)
    );

    sdram_boot_top #(.ZERO_WORDS(ZERO_WORDS)) DUT (.*);

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    // ============================================================
    // Reporting
    // ============================================================

    task automatic abort_run(input string what);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", what);
    endtask

    task automatic check_word(input string name, input sdram_boot_pkg::sdram_data_t expected,
                              input sdram_boot_pkg::sdram_data_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            abort_run("data word mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
            abort_run("flag mismatch");
        end
    endtask

    // ============================================================
    // SDRAM behavioral model
    // ============================================================

    // ROM select bit and the low 12 word bits
    function automatic int mem_index(input sdram_boot_pkg::sdram_addr_t a);
        return int'({a[22], a[12:1]});
    endfunction

    function automatic logic in_model_range(input sdram_boot_pkg::sdram_addr_t a);
        return (a[0] == 1'b0) && (a[24:23] == '0) && (a[21:13] == '0);
    endfunction

    task automatic fill_memory();
        int i;
        for (i = 0; i < MEM_WORDS; i++) begin
            mem[i]      = sdram_boot_pkg::sdram_data_t'($random(seed)) ^ 16'(i);
            wr_count[i] = 0;
        end
    endtask

    // One access at a time, busy for 3 to 6 cycles after the pulse
    always @(posedge clk_sys) begin
        if (rst) begin
            sdram_busy  <= 1'b0;
            busy_left   <= 0;
            done_rom    <= 1'b0;
            rom_access  <= 1'b0;
            done_zero   <= 1'b0;
            zero_access <= 1'b0;
        end else begin
            done_rom  <= 1'b0;
            done_zero <= 1'b0;
            if (sdram_rd || sdram_wr) begin
                if (sdram_busy) begin
                    abort_run("SDRAM request issued while the model was busy");
                end
                if (!in_model_range(sdram_addr)) begin
                    abort_run($sformatf("SDRAM access at %h outside modeled range", sdram_addr));
                end
                // Every access in this test is a single word
                check_flag("sdram_word on request", 1'b1, sdram_word);
                check_flag("sdram_burst on request", 1'b0, sdram_burst);
                if (sdram_wr) begin
                    mem[mem_index(sdram_addr)]      <= sdram_din;
                    wr_count[mem_index(sdram_addr)] <= wr_count[mem_index(sdram_addr)] + 1;
                end else if (!sdram_refresh) begin
                    sdram_dout <= mem[mem_index(sdram_addr)];
                end
                busy_left   <= 3 + int'($unsigned($random(seed)) % 4);
                sdram_busy  <= 1'b1;
                rom_access  <= sdram_wr && sdram_addr[22];
                zero_access <= sdram_wr
                               && (sdram_addr < sdram_boot_pkg::sdram_addr_t'(2 * ZERO_WORDS));
            end else if (sdram_busy) begin
                busy_left <= busy_left - 1;
                if (busy_left == 1) begin
                    sdram_busy <= 1'b0;
                    done_rom   <= rom_access;
                    done_zero  <= zero_access;
                end
            end
        end
    end

    // ============================================================
    // Monitors
    // ============================================================

    // core_reset follows its causes one cycle late
    // Causes come from the host inputs and the model's own write tracking
    always @(posedge clk_sys) begin
        if (monitor_armed) begin
            check_flag("core_reset follows its causes", reset_cause_q, core_reset);
            if (rom_pending) begin
                check_flag("dl_ready while ROM write pending", 1'b0, dl_ready);
            end
        end
        // Causes in the cycle that just ended
        reset_cause_q = rst || menu_reset || dl_active || rom_pending
                        || (zero_writes < ZERO_WORDS);
        if (done_rom) begin
            rom_pending = 1'b0;
            rom_writes  = rom_writes + 1;
        end
        if (dl_valid && dl_ready) begin
            rom_pending = 1'b1;
        end
        // Sweep progress restarts on reset and on each new download
        if (rst || (dl_active && !dl_active_prev)) begin
            zero_writes = 0;
        end else if (done_zero) begin
            zero_writes = zero_writes + 1;
        end
        dl_active_prev = dl_active && !rst;
        monitor_armed  = 1'b1;
    end

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            abort_run($sformatf("timeout, run exceeded %0d cycles", cycle_limit));
        end
    end

    // ============================================================
    // Stimulus helpers
    // ============================================================

    task automatic load_testdata();
        int i;
        for (i = 0; i < 3 * MAX_RECORDS; i++) begin
            testdata[i] = '0;
        end
        $readmemh("verif/sdram_boot_testdata.hex", testdata);
        n_records   = 0;
        n_downloads = 0;
        while (n_records < MAX_RECORDS && testdata[3*n_records] != 0) begin
            if (testdata[3*n_records] == 1) begin
                n_downloads++;
            end
            n_records++;
        end
        if (n_records == 0) begin
            abort_run("no records found in verif/sdram_boot_testdata.hex");
        end
        // Download plus two ROM readbacks, three sweeps and their zero readbacks
        cycle_limit = 40 * n_records * 2 + 20 * ZERO_WORDS * 3;
    endtask

    // Single core access once bring-up has released the port
    // Between accesses the core idles with byte mode and burst set
    task automatic core_access(input sdram_boot_pkg::sdram_addr_t addr, input logic write,
                               input sdram_boot_pkg::sdram_data_t wdata,
                               output sdram_boot_pkg::sdram_data_t rdata);
        @(posedge clk_sys);
        while (core_reset || sdram_busy) @(posedge clk_sys);
        core_addr  <= addr;
        core_din   <= wdata;
        core_rd    <= !write;
        core_wr    <= write;
        core_word  <= 1'b1;
        core_burst <= 1'b0;
        @(posedge clk_sys);
        core_rd    <= 1'b0;
        core_wr    <= 1'b0;
        core_word  <= 1'b0;
        core_burst <= 1'b1;
        // Busy rises after the pulse, its fall ends the access
        @(posedge clk_sys);
        while (sdram_busy) @(posedge clk_sys);
        rdata = sdram_dout;
    endtask

    task automatic wait_core_release();
        @(posedge clk_sys);
        while (core_reset) @(posedge clk_sys);
    endtask

    task automatic zero_region_readback(input string pass_name);
        int w;
        sdram_boot_pkg::sdram_data_t data;
        for (w = 0; w < ZERO_WORDS; w++) begin
            core_access(sdram_boot_pkg::sdram_addr_t'(w) << 1, 1'b0, 16'h0000, data);
            check_word($sformatf("%s zero word %0d", pass_name, w), 16'h0000, data);
        end
    endtask

    task automatic rom_region_readback(input string pass_name);
        int i;
        sdram_boot_pkg::sdram_data_t data;
        for (i = 0; i < n_records; i++) begin
            if (testdata[3*i] == 2) begin
                core_access(sdram_boot_pkg::sdram_addr_t'(testdata[3*i+1]), 1'b0, 16'h0000, data);
                check_word($sformatf("%s read at %h", pass_name, testdata[3*i+1]),
                           testdata[3*i+2][15:0], data);
            end
        end
    endtask

    // Valid stays high from the first word to the last
    task automatic download_records();
        int i;
        @(posedge clk_sys);
        dl_active <= 1'b1;
        for (i = 0; i < n_records; i++) begin
            if (testdata[3*i] == 1) begin
                dl_addr  <= sdram_boot_pkg::dl_addr_t'(testdata[3*i+1]);
                dl_data  <= testdata[3*i+2][15:0];
                dl_valid <= 1'b1;
                @(posedge clk_sys);
                while (!dl_ready) @(posedge clk_sys);
            end
        end
        dl_valid  <= 1'b0;
        dl_active <= 1'b0;
    endtask

    // Each downloaded word must be written to SDRAM exactly once
    task automatic rom_write_counts();
        int i;
        logic [31:0] host_addr;
        sdram_boot_pkg::sdram_addr_t a;
        for (i = 0; i < n_records; i++) begin
            if (testdata[3*i] == 1) begin
                host_addr = testdata[3*i+1];
                a = sdram_boot_pkg::ROM_BASE + sdram_boot_pkg::sdram_addr_t'(
                        {host_addr[sdram_boot_pkg::ROM_ADDR_BITS:1], 1'b0});
                check_flag($sformatf("single write at %h", a), 1'b1, wr_count[mem_index(a)] == 1);
            end
        end
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial begin
        sdram_boot_pkg::sdram_data_t data;
        rst            = 1'b1;
        menu_reset     = 1'b0;
        dl_active      = 1'b0;
        dl_valid       = 1'b0;
        dl_addr        = '0;
        dl_data        = '0;
        core_addr      = '0;
        core_rd        = 1'b0;
        core_wr        = 1'b0;
        core_word      = 1'b0;
        core_din       = '0;
        core_refresh   = 1'b0;
        core_burst     = 1'b1;
        sdram_busy     = 1'b0;
        sdram_dout     = '0;
        done_rom       = 1'b0;
        done_zero      = 1'b0;
        rom_writes     = 0;
        zero_writes    = 0;
        cycle_count    = 0;
        cycle_limit    = 0;
        rom_pending    = 1'b0;
        dl_active_prev = 1'b0;
        fill_memory();
        load_testdata();

        repeat (3) @(posedge clk_sys);
        check_flag("core_reset after rst", 1'b1, core_reset);
        check_flag("dl_ready after rst", 1'b1, dl_ready);
        rst <= 1'b0;

        // Power-up sweep, then zero readback
        wait_core_release();
        zero_region_readback("first sweep");

        // Download with continuous valid
        download_records();
        wait_core_release();
        check_flag("ROM write count", 1'b1, rom_writes == n_downloads);
        rom_write_counts();
        rom_region_readback("after download");

        // Dirty one zero word so the next sweep has work to show
        core_access(sdram_boot_pkg::sdram_addr_t'(10), 1'b1, 16'hbeef, data);
        core_access(sdram_boot_pkg::sdram_addr_t'(10), 1'b0, 16'h0000, data);
        check_word("core write to zero region", 16'hbeef, data);

        // New dl_active edge restarts the sweep
        @(posedge clk_sys);
        dl_active <= 1'b1;
        @(posedge clk_sys);
        @(posedge clk_sys);
        check_flag("core_reset raised by dl_active", 1'b1, core_reset);
        dl_active <= 1'b0;
        // Core read held during bring-up must stay off the SDRAM
        core_rd <= 1'b1;
        repeat (4) @(posedge clk_sys);
        core_rd <= 1'b0;
        wait_core_release();
        zero_region_readback("second sweep");
        rom_region_readback("after restart");

        if (DUT.u_arbiter.u_props.failures == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/sdram_boot_testdata.hex ====
// Columns: kind, address, data
// kind 1 = download word (host byte address, word as sent)
// kind 2 = core read check (SDRAM byte address, expected word)
1 0000000 1234
1 0000002 abcd
1 0000004 0f1e
1 0000006 8001
1 00001a0 5ac3
1 0000ffe beef
1 0001234 7e81
1 0001ffe c0de
// Bits above 21 of the host address are ignored
1 0c00020 1357
2 0400000 3412
2 0400002 cdab
2 0400004 1e0f
2 0400006 0180
2 04001a0 c35a
2 0400ffe efbe
2 0401234 817e
2 0401ffe dec0
2 0400020 5713
